//--- Bender.yml
package:
  name: csr_index_generator

sources:
  - files:
      - csr_index_pkg.sv
      - csr_index_config_regs.sv
      - csr_index_sequencer.sv
      - csr_index_request_build.sv
      - csr_index_request_fifo.sv
      - csr_index_generator.sv
  - target: test
    files:
      - tb_csr_index_generator.sv

//--- csr_index_config_regs.sv
// CSR index configuration registers
module csr_index_config_regs (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  logic                            config_valid,
    input  csr_index_pkg::csr_index_config_t config_in,
    input  logic                            idle,
    output csr_index_pkg::csr_index_config_t cfg,
    output logic                            start
);

    logic accept;

    // ------------------------------
    // Capture
    // ------------------------------
    // Only taken while the sequencer is idle and no start is pending,
    // so cfg stays frozen for the whole run
    assign accept = config_valid & idle & ~start;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end

        if (accept) begin
            cfg <= config_in;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Start has to land while the sequencer can still take it
    start_while_idle : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        start |-> idle
    ) else $error("start pulsed while the sequencer was not idle");

endmodule : csr_index_config_regs

//--- csr_index_generator.f
csr_index_pkg.sv
csr_index_config_regs.sv
csr_index_sequencer.sv
csr_index_request_build.sv
csr_index_request_fifo.sv
csr_index_generator.sv
tb_csr_index_generator.sv

//--- csr_index_generator.sv
// CSR index generator top level
module csr_index_generator #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                            ap_clk,
    input  logic                            areset_generator,
    input  logic                            config_valid,
    input  csr_index_pkg::csr_index_config_t config_in,
    input  logic                            request_ready,
    output csr_index_pkg::csr_request_t      request_out,
    output logic                            done
);

    import csr_index_pkg::*;

    csr_index_config_t      cfg;
    csr_request_t           fifo_din;
    logic                   start;
    logic                   idle;
    logic                   push;
    logic                   prog_full;
    logic [index_width-1:0] index;

    csr_index_config_regs i_config_regs (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_valid     (config_valid),
        .config_in        (config_in),
        .idle             (idle),
        .cfg              (cfg),
        .start            (start)
    );

    csr_index_sequencer i_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .index_start      (cfg.index_start),
        .index_end        (cfg.index_end),
        .prog_full        (prog_full),
        .idle             (idle),
        .done             (done),
        .push             (push),
        .index            (index)
    );

    csr_index_request_build i_request_build (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .index            (index),
        .cfg              (cfg),
        .fifo_din         (fifo_din)
    );

    // ------------------------------
    // Request queue
    // ------------------------------
    csr_index_request_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) i_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .din              (fifo_din),
        .rd_ready         (request_ready),
        .prog_full        (prog_full),
        .dout             (request_out)
    );

endmodule : csr_index_generator

//--- csr_index_pkg.sv
// CSR index generator types
package csr_index_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    parameter int index_width = 32;
    parameter int shift_width = 5;
    parameter int route_width = 8;

    // ------------------------------
    // Configuration word
    // ------------------------------
    // One run covers index_start up to index_end - 1
    typedef struct packed {
        logic [index_width-1:0] array_pointer;
        logic [index_width-1:0] index_start;
        logic [index_width-1:0] index_end;
        logic [shift_width-1:0] shift_amount;
        logic                   shift_left;
        logic [route_width-1:0] route;
    } csr_index_config_t;

    // ------------------------------
    // Memory request
    // ------------------------------
    // Address is base + offset, index travels along for the consumer
    typedef struct packed {
        logic                   valid;
        logic [route_width-1:0] route;
        logic [index_width-1:0] base;
        logic [index_width-1:0] offset;
        logic [index_width-1:0] index;
    } csr_request_t;

    // Sequencer states
    typedef enum logic [2:0] {
        gen_idle,
        gen_start,
        gen_busy,
        gen_pause,
        gen_done
    } gen_state_t;

endpackage : csr_index_pkg

//--- csr_index_request_build.sv
// CSR index request builder
module csr_index_request_build (
    input  logic                                ap_clk,
    input  logic                                areset_generator,
    input  logic                                push,
    input  logic [csr_index_pkg::index_width-1:0] index,
    input  csr_index_pkg::csr_index_config_t     cfg,
    output csr_index_pkg::csr_request_t          fifo_din
);

    import csr_index_pkg::*;

    logic [index_width-1:0] offset;

    // ------------------------------
    // Address offset
    // ------------------------------
    // Element size as a power of two, or a packed sub-word index
    always_comb begin
        if (cfg.shift_left) begin
            offset = index << cfg.shift_amount;
        end else begin
            offset = index >> cfg.shift_amount;
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            fifo_din.valid <= 1'b0;
        end else begin
            fifo_din.valid <= push;
        end

        fifo_din.route  <= cfg.route;
        fifo_din.base   <= cfg.array_pointer;
        fifo_din.offset <= offset;
        fifo_din.index  <= index;
    end

endmodule : csr_index_request_build

//--- csr_index_request_fifo.sv
// CSR request queue
module csr_index_request_fifo #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  csr_index_pkg::csr_request_t din,
    input  logic                       rd_ready,
    output logic                       prog_full,
    output csr_index_pkg::csr_request_t dout
);

    import csr_index_pkg::*;

    localparam int addr_width  = $clog2(FIFO_DEPTH);
    localparam int count_width = $clog2(FIFO_DEPTH + 1);

    csr_request_t           mem [FIFO_DEPTH];
    logic [addr_width-1:0]  wr_ptr;
    logic [addr_width-1:0]  rd_ptr;
    logic [count_width-1:0] count;
    logic                   wr_en;
    logic                   rd_en;
    logic                   empty;
    logic                   full;

    assign wr_en     = din.valid;
    assign empty     = (count == '0);
    assign full      = (count == count_width'(FIFO_DEPTH));
    assign rd_en     = rd_ready & ~empty;
    assign prog_full = (count >= count_width'(PROG_THRESH));

    // ------------------------------
    // Pointers and fill level
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == addr_width'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == addr_width'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + count_width'(wr_en) - count_width'(rd_en);
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // Registered read, valid one cycle after the pop
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            dout.valid <= 1'b0;
        end else begin
            dout.valid <= rd_en;
        end

        if (rd_en) begin
            dout.route  <= mem[rd_ptr].route;
            dout.base   <= mem[rd_ptr].base;
            dout.offset <= mem[rd_ptr].offset;
            dout.index  <= mem[rd_ptr].index;
        end
    end

    // Threshold headroom has to cover the requests still in flight
    no_write_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        wr_en |-> !full
    ) else $error("request queue written while full");

endmodule : csr_index_request_fifo

//--- csr_index_sequencer.sv
// CSR index run sequencer
module csr_index_sequencer (
    input  logic                                ap_clk,
    input  logic                                areset_generator,
    input  logic                                start,
    input  logic [csr_index_pkg::index_width-1:0] index_start,
    input  logic [csr_index_pkg::index_width-1:0] index_end,
    input  logic                                prog_full,
    output logic                                idle,
    output logic                                done,
    output logic                                push,
    output logic [csr_index_pkg::index_width-1:0] index
);

    import csr_index_pkg::*;

    gen_state_t state;
    gen_state_t next_state;
    logic       in_range;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= gen_idle;
        end else begin
            state <= next_state;
        end
    end

    assign in_range = index < index_end;

    always_comb begin
        next_state = state;
        case (state)
            gen_idle: begin
                if (start) begin
                    next_state = gen_start;
                end
            end
            // Counter is loaded, one settle cycle before issuing
            gen_start: begin
                next_state = gen_busy;
            end
            gen_busy: begin
                if (!in_range) begin
                    next_state = gen_done;
                end else if (prog_full) begin
                    next_state = gen_pause;
                end
            end
            gen_pause: begin
                if (!prog_full) begin
                    next_state = gen_busy;
                end
            end
            gen_done: begin
                next_state = gen_idle;
            end
            default: begin
                next_state = gen_idle;
            end
        endcase
    end

    // ------------------------------
    // Index counter
    // ------------------------------
    // One index per cycle, held while the queue is above threshold
    assign push = (state == gen_busy) & in_range & ~prog_full;
    assign idle = (state == gen_idle);

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            index <= '0;
        end else if (idle && start) begin
            index <= index_start;
        end else if (push) begin
            index <= index + 1'b1;
        end
    end

    // Done level, low from start until the run has left gen_done
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done <= 1'b1;
        end else if (idle && start) begin
            done <= 1'b0;
        end else if (state == gen_done) begin
            done <= 1'b1;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    push_in_range : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        push |-> (index < index_end) && (index >= index_start)
    ) else $error("push outside of the configured index range");

endmodule : csr_index_sequencer

//--- tb_csr_index_generator.sv
// CSR index generator testbench
module tb_csr_index_generator;

    import csr_index_pkg::*;

    localparam int clk_period    = 4;
    localparam int fifo_depth    = 16;
    localparam int run_budget    = 600;
    localparam int num_tests     = 12;
    localparam int watchdog_time = num_tests * run_budget * clk_period + 2000;

    logic                   ap_clk;
    logic                   areset_generator;
    logic                   config_valid;
    csr_index_config_t      config_in;
    logic                   request_ready;
    csr_request_t           request_out;
    logic                   done;
    // Model of the run the DUT should be producing
    csr_index_config_t      exp_cfg;
    logic [index_width-1:0] exp_len;
    logic [index_width-1:0] exp_index;
    logic [index_width-1:0] seen;
    logic                   clear_seen;
    logic                   configured;
    logic                   check_count;
    logic                   drained;
    logic                   hold_low;
    int                     ready_mode;
    int                     errors;
    int                     tests_run;
    int                     tests_failed;
    int                     errors_at_start;

    csr_index_generator i_dut (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_valid     (config_valid),
        .config_in        (config_in),
        .request_ready    (request_ready),
        .request_out      (request_out),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(clk_period / 2) ap_clk = ~ap_clk;
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog expired, the run timed out before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    // Requests seen so far in the current run
    always @(posedge ap_clk) begin
        if (areset_generator || clear_seen) begin
            seen <= '0;
        end else if (request_out.valid) begin
            seen <= seen + 32'd1;
        end
    end

    assign exp_index = exp_cfg.index_start + seen;

    // ------------------------------
    // Checks
    // ------------------------------
    reset_state_held : assert property (@(posedge ap_clk) disable iff (areset_generator)
        !configured |-> done && !request_out.valid
    ) else report_mismatch("done low or request valid before any configuration");
    request_index_ok : assert property (@(posedge ap_clk) disable iff (areset_generator)
        request_out.valid |-> request_out.index == exp_index
    ) else report_mismatch("request index out of sequence");
    request_fields_ok : assert property (@(posedge ap_clk) disable iff (areset_generator)
        request_out.valid |-> request_out.base == exp_cfg.array_pointer
            && request_out.route == exp_cfg.route
    ) else report_mismatch("request base or route differs from configuration");
    request_offset_ok : assert property (@(posedge ap_clk) disable iff (areset_generator)
        request_out.valid |-> request_out.offset == expected_offset(exp_index, exp_cfg)
    ) else report_mismatch("request offset is not the shifted index");
    run_count_ok : assert property (@(posedge ap_clk) disable iff (areset_generator)
        check_count |-> seen == exp_len
    ) else report_mismatch("request count differs from index_end - index_start");
    quiet_after_drain : assert property (@(posedge ap_clk) disable iff (areset_generator)
        drained |-> !request_out.valid
    ) else report_mismatch("request appeared after the run had drained");
    done_held_low : assert property (@(posedge ap_clk) disable iff (areset_generator)
        hold_low |-> !done
    ) else report_mismatch("done rose while generation was stalled");

    task automatic report_mismatch(input string what);
        $display("[FAIL] %0t: %s", $time, what);
        errors++;
    endtask

    // Scale by a power of two, or divide down by one
    function automatic logic [index_width-1:0] expected_offset(
        input logic [index_width-1:0] idx, input csr_index_config_t c);
        logic [index_width-1:0] r;
        r = idx;
        for (int i = 0; i < int'(c.shift_amount); i++) begin
            if (c.shift_left) begin
                r = r * 32'd2;
            end else begin
                r = r / 32'd2;
            end
        end
        return r;
    endfunction

    function automatic csr_index_config_t random_config(input logic shl);
        csr_index_config_t c;
        c.array_pointer = $urandom;
        c.index_start   = 32'd16 + ($urandom % 32'd1000);
        c.index_end     = c.index_start + 32'd1 + ($urandom % 32'd40);
        c.shift_amount  = shift_width'($urandom);
        c.shift_left    = shl;
        c.route         = route_width'($urandom);
        return c;
    endfunction

    // Advance to the next falling edge and drive the ready level
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(negedge ap_clk);
            case (ready_mode)
                0: request_ready = 1'b0;
                1: request_ready = ($urandom % 4) != 0;
                default: request_ready = 1'b1;
            endcase
        end
    endtask

    task automatic send_config(input csr_index_config_t c);
        config_in    = c;
        config_valid = 1'b1;
        clear_seen   = 1'b1;
        configured   = 1'b1;
        drained      = 1'b0;
        exp_cfg      = c;
        exp_len      = (c.index_start < c.index_end) ? c.index_end - c.index_start : '0;
        step_cycles(1);
        config_valid = 1'b0;
        clear_seen   = 1'b0;
    endtask

    task automatic send_ignored_config(input csr_index_config_t c);
        config_in    = c;
        config_valid = 1'b1;
        step_cycles(1);
        config_valid = 1'b0;
    endtask

    task automatic wait_level(input logic level);
        int n;
        n = 0;
        while (done !== level && n < run_budget) begin
            step_cycles(1);
            n++;
        end
        if (done !== level) begin
            $display("Timed out after %0d cycles waiting for done = %0b", run_budget, level);
            errors++;
        end
    endtask

    // Empty the queue, then compare the run length
    task automatic drain_check();
        ready_mode = 2;
        step_cycles(fifo_depth + 4);
        check_count = 1'b1;
        step_cycles(1);
        check_count = 1'b0;
        drained     = 1'b1;
        step_cycles(3);
    endtask

    task automatic run_one(input csr_index_config_t c);
        ready_mode = 1;
        send_config(c);
        wait_level(1'b0);
        wait_level(1'b1);
        drain_check();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        csr_index_config_t c;
        void'($urandom(32'he2780231));
        areset_generator = 1'b1;
        config_valid     = 1'b0;
        config_in        = '0;
        request_ready    = 1'b0;
        exp_cfg          = '0;
        exp_len          = '0;
        clear_seen       = 1'b0;
        configured       = 1'b0;
        check_count      = 1'b0;
        drained          = 1'b0;
        hold_low         = 1'b0;
        ready_mode       = 1;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        errors_at_start  = 0;
        step_cycles(5);
        areset_generator = 1'b0;
        step_cycles(20);
        finish_test("reset state");
        repeat (4) run_one(random_config(1'b1));
        finish_test("random ranges, left shift");
        repeat (3) run_one(random_config(1'b0));
        finish_test("random ranges, right shift");
        c = random_config(1'b1);
        c.index_end = c.index_start;
        run_one(c);
        c.index_end = c.index_start - 32'd5;
        run_one(c);
        finish_test("empty ranges");
        // Longer than the queue, so generation has to stall
        c = random_config(1'b1);
        c.index_end = c.index_start + 32'(3 * fifo_depth);
        ready_mode = 0;
        send_config(c);
        wait_level(1'b0);
        // Held past the whole range, so only a stall keeps done low
        hold_low = 1'b1;
        step_cycles(3 * fifo_depth + 16);
        hold_low   = 1'b0;
        ready_mode = 1;
        wait_level(1'b1);
        drain_check();
        finish_test("back-pressure");
        c = random_config(1'b1);
        c.index_end = c.index_start + 32'd30;
        ready_mode = 1;
        send_config(c);
        wait_level(1'b0);
        step_cycles(3);
        send_ignored_config(random_config(1'b0));
        wait_level(1'b1);
        drain_check();
        finish_test("config during run");
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_csr_index_generator
